/* pagerank_cu.f */
verilog/pagerank_pkg.sv
verilog/sync_fifo.sv
verilog/response_decoder.sv
verilog/edge_job_control.sv
verilog/edge_data_control.sv
verilog/read_command_arbiter.sv
verilog/rank_sum_kernel.sv
verilog/pagerank_cu.sv
verification/tb_pagerank_cu.sv

/* verification/tb_pagerank_cu.sv */
// Testbench for the PageRank vertex compute unit with an in-order read memory model
`timescale 1ns/1ps

module tb_pagerank_cu;

	localparam int NUM_JOBS       = 12;
	localparam int HOLD_CYCLES    = 60;
	localparam int TIMEOUT_CYCLES = 200 * NUM_JOBS + 2000;

	logic                                   clock = 1'b0;
	logic                                   rstn;
	logic                                   enabled_in;
	pagerank_pkg::vertex_job_t              vertex_job;
	logic                                   vertex_job_request;
	pagerank_pkg::read_response_t           read_response;
	logic                                   read_command_bus_grant;
	logic                                   read_command_bus_request;
	pagerank_pkg::read_command_t            read_command_out;
	pagerank_pkg::edge_write_t              edge_data_write_out;
	logic [pagerank_pkg::COUNTER_BITS-1:0] vertex_num_counter;
	logic [pagerank_pkg::COUNTER_BITS-1:0] edge_num_counter;

	// Job list and expected sums
	logic [15:0] job_id    [NUM_JOBS];
	logic [15:0] job_start [NUM_JOBS];
	logic [15:0] job_count [NUM_JOBS];
	logic [31:0] job_sum   [NUM_JOBS];
	int          total_edges;

	// Memory model state
	pagerank_pkg::read_response_t response_queue[$];
	int                           response_due[$];
	logic [15:0]                  returned_neighbours[$];
	int                           last_due;

	integer seed;
	int     cycle;
	int     phase;
	logic   hold_grant;
	int     hold_count;
	int     job_index;
	int     write_index;
	int     read_count;
	int     edge_cmd_job;
	int     edge_cmd_offset;
	int     error_count;
	int     check_count;

	pagerank_cu i_dut (
		.clock                   (clock                   ),
		.rstn                    (rstn                    ),
		.enabled_in              (enabled_in              ),
		.vertex_job              (vertex_job              ),
		.vertex_job_request      (vertex_job_request      ),
		.read_response           (read_response           ),
		.read_command_bus_grant  (read_command_bus_grant  ),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out        ),
		.edge_data_write_out     (edge_data_write_out     ),
		.vertex_num_counter      (vertex_num_counter      ),
		.edge_num_counter        (edge_num_counter        )
	);

	initial begin
		forever #10 clock = ~clock;
	end

	////////////////////
	// Helpers
	////////////////////

	task automatic report_mismatch(input string msg);
		error_count++;
		$display("mismatch at %0d ns: %s", $time, msg);
	endtask

	task automatic note_failure(input string msg);
		error_count++;
		$display("error at %0d ns: %s", $time, msg);
	endtask

	task automatic expect_equal(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		check_count++;
		assert (got === expected) else
			report_mismatch($sformatf("%s is %0h, expected %0h", what, got, expected));
	endtask

	task automatic print_counts();
		$display("checks %0d, errors %0d", check_count, error_count);
	endtask

	// Edge array content
	function automatic logic [15:0] neighbour_of(input logic [15:0] address);
		return address * 16'd7 + 16'd3;
	endfunction

	// Graph data content
	function automatic logic [31:0] rank_of(input logic [15:0] n);
		logic [31:0] wide;
		wide = {16'h0, n};
		return wide * wide + 32'd1;
	endfunction

	task automatic build_job_list();
		logic [31:0] rnd;
		logic [31:0] sum;
		total_edges = 0;
		for (int i = 0; i < NUM_JOBS; i++) begin
			job_id[i] = 16'h0100 + i[15:0];
			rnd = $random(seed);
			job_start[i] = rnd[15:0];
			rnd = $random(seed);
			job_count[i] = rnd[15:0] % 16'd7;
			// One empty vertex and one full vertex for sure
			if (i == 2) begin
				job_count[i] = 16'd0;
			end
			if (i == 7) begin
				job_count[i] = 16'd6;
			end
			sum = '0;
			for (int k = 0; k < job_count[i]; k++) begin
				sum = sum + rank_of(neighbour_of(job_start[i] + k[15:0]));
			end
			job_sum[i] = sum;
			total_edges += job_count[i];
		end
	endtask

	////////////////////
	// Checks, memory model and drivers
	////////////////////

	always @(negedge clock) begin : model
		pagerank_pkg::read_response_t response;
		logic [31:0]                  rnd;
		logic [15:0]                  offset;
		int                           gap;
		int                           found;

		cycle++;

		// Quiet outputs in reset, after reset and while enable is low
		if (phase == 0) begin
			expect_equal(vertex_job_request, 0, "vertex_job_request in reset");
		end
		if (phase <= 2) begin
			expect_equal(read_command_out.valid, 0, "read command valid before enable");
			expect_equal(read_command_bus_request, 0, "bus request before enable");
			expect_equal(edge_data_write_out.valid, 0, "write valid before enable");
			expect_equal(vertex_num_counter, 0, "vertex counter before enable");
			expect_equal(edge_num_counter, 0, "edge counter before enable");
		end

		// Two cycles for the registered grant to drain
		if (hold_grant) begin
			if (hold_count >= 2) begin
				check_count++;
				assert (!read_command_out.valid) else
					report_mismatch("read command valid while grant is withheld");
			end
			hold_count++;
		end else begin
			hold_count = 0;
		end

		if (edge_data_write_out.valid) begin
			if (write_index >= NUM_JOBS) begin
				note_failure("a write appeared after every job had finished");
			end else begin
				expect_equal(edge_data_write_out.vertex_id, job_id[write_index],
					"write vertex id");
				expect_equal(edge_data_write_out.rank_sum, job_sum[write_index],
					$sformatf("rank sum of vertex %0h", job_id[write_index]));
				write_index++;
			end
		end

		if (read_command_out.valid) begin
			read_count++;
			response       = '0;
			response.valid = 1'b1;
			response.tag   = read_command_out.tag;
			if (read_command_out.tag == pagerank_pkg::EDGE_ARRAY) begin
				// Skip finished and empty vertices
				while (edge_cmd_job < NUM_JOBS && edge_cmd_offset >= job_count[edge_cmd_job]) begin
					edge_cmd_job++;
					edge_cmd_offset = 0;
				end
				if (edge_cmd_job >= NUM_JOBS) begin
					note_failure("an edge-array read came after all edges were read");
				end else begin
					offset = read_command_out.address - job_start[edge_cmd_job];
					check_count++;
					assert (offset < job_count[edge_cmd_job]) else
						report_mismatch($sformatf("edge-array read %0h outside vertex %0h",
							read_command_out.address, job_id[edge_cmd_job]));
					edge_cmd_offset++;
				end
				response.word.edge_array.neighbour_id = neighbour_of(read_command_out.address);
			end else if (read_command_out.tag == pagerank_pkg::GRAPH_DATA) begin
				found = -1;
				for (int i = 0; i < returned_neighbours.size(); i++) begin
					if (found < 0 && returned_neighbours[i] == read_command_out.address) begin
						found = i;
					end
				end
				check_count++;
				assert (found >= 0) else
					report_mismatch($sformatf("graph-data read %0h is not a returned neighbour",
						read_command_out.address));
				if (found >= 0) begin
					returned_neighbours.delete(found);
				end
				response.word.graph_data = rank_of(read_command_out.address);
			end else begin
				note_failure("a read command carried the idle array tag");
			end
			// In-order answers 1 to 6 cycles later
			rnd = $random(seed);
			gap = 1 + int'(rnd % 6);
			if (cycle + gap > last_due) begin
				last_due = cycle + gap;
			end else begin
				last_due = last_due + 1;
			end
			response_queue.push_back(response);
			response_due.push_back(last_due);
		end

		if (response_queue.size() > 0 && response_due[0] <= cycle) begin
			response = response_queue.pop_front();
			response_due.delete(0);
			if (response.tag == pagerank_pkg::EDGE_ARRAY) begin
				returned_neighbours.push_back(response.word.edge_array.neighbour_id);
			end
			read_response = response;
		end else begin
			read_response = '0;
		end

		rnd = $random(seed);
		read_command_bus_grant = read_command_bus_request && !hold_grant && rnd[0];

		// Job source obeys the request flag
		if (phase >= 2 && job_index < NUM_JOBS && vertex_job_request) begin
			vertex_job.valid      = 1'b1;
			vertex_job.vertex_id  = job_id[job_index];
			vertex_job.edge_start = job_start[job_index];
			vertex_job.edge_count = job_count[job_index];
			job_index++;
		end else begin
			vertex_job = '0;
		end
	end

	////////////////////
	// Sequence
	////////////////////

	initial begin
		seed                   = 32'h7a6c57c5;
		rstn                   = 1'b0;
		enabled_in             = 1'b0;
		vertex_job             = '0;
		read_response          = '0;
		read_command_bus_grant = 1'b0;
		phase                  = 0;
		hold_grant             = 1'b0;
		hold_count             = 0;
		cycle                  = 0;
		job_index              = 0;
		write_index            = 0;
		read_count             = 0;
		edge_cmd_job           = 0;
		edge_cmd_offset        = 0;
		last_due               = 0;
		error_count            = 0;
		check_count            = 0;
		build_job_list();

		repeat (4) @(negedge clock);
		rstn = 1'b1;
		@(posedge clock);
		phase = 1;
		repeat (10) @(posedge clock);
		// Jobs queue up while the unit is disabled
		phase = 2;
		repeat (30) @(posedge clock);
		@(negedge clock);
		enabled_in = 1'b1;
		@(posedge clock);
		phase = 3;

		// Back-pressure phase in the middle of the work
		wait (write_index >= 3);
		@(posedge clock);
		hold_grant = 1'b1;
		repeat (HOLD_CYCLES) @(posedge clock);
		hold_grant = 1'b0;

		wait (write_index == NUM_JOBS);
		repeat (20) @(posedge clock);
		#5;
		expect_equal(vertex_num_counter, NUM_JOBS, "vertex_num_counter");
		expect_equal(edge_num_counter, total_edges, "edge_num_counter");
		expect_equal(read_count, 2 * total_edges, "number of read commands");
		check_count++;
		assert (response_queue.size() == 0 && returned_neighbours.size() == 0) else
			note_failure("some neighbour ids never got their graph-data read");

		print_counts();
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		note_failure($sformatf("run did not finish in %0d cycles, %0d of %0d writes seen",
			TIMEOUT_CYCLES, write_index, NUM_JOBS));
		print_counts();
		$display("Test FAILED");
		$finish;
	end

endmodule

/* verilog/pagerank_cu.sv */
// PageRank vertex compute unit top, vertex queue, controllers, command arbiter and sum kernel
`timescale 1ns/1ps

module pagerank_cu (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  logic                                   enabled_in,
	input  pagerank_pkg::vertex_job_t              vertex_job,
	output logic                                   vertex_job_request,
	input  pagerank_pkg::read_response_t           read_response,
	input  logic                                   read_command_bus_grant,
	output logic                                   read_command_bus_request,
	output pagerank_pkg::read_command_t            read_command_out,
	output pagerank_pkg::edge_write_t              edge_data_write_out,
	output logic [pagerank_pkg::COUNTER_BITS-1:0] vertex_num_counter,
	output logic [pagerank_pkg::COUNTER_BITS-1:0] edge_num_counter
);

	logic                         enabled;
	logic                         vertex_queue_almost_full;
	logic                         job_pop;
	logic                         stall;
	logic                         vertex_done;
	pagerank_pkg::vertex_job_t    queued_job;
	pagerank_pkg::vertex_job_t    current_job;
	pagerank_pkg::read_command_t  job_command;
	pagerank_pkg::read_command_t  data_command;
	pagerank_pkg::read_response_t edge_array_response;
	pagerank_pkg::read_response_t graph_data_response;

	////////////////////
	// Enable and job request
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled            <= 1'b0;
			vertex_job_request <= 1'b0;
		end else begin
			enabled            <= enabled_in;
			vertex_job_request <= !vertex_queue_almost_full;
		end
	end

	// Vertex job queue
	sync_fifo #(
		.WIDTH($bits(pagerank_pkg::vertex_job_t)),
		.DEPTH(pagerank_pkg::VERTEX_QUEUE_DEPTH )
	) i_vertex_queue (
		.clock      (clock                   ),
		.rstn       (rstn                    ),
		.push       (vertex_job.valid        ),
		.data_in    (vertex_job              ),
		.pop        (job_pop                 ),
		.data_out   (queued_job              ),
		.full       (                        ),
		.almost_full(vertex_queue_almost_full),
		.empty      (                        )
	);

	response_decoder i_response_decoder (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.response           (read_response      ),
		.edge_array_response(edge_array_response),
		.graph_data_response(graph_data_response)
	);

	////////////////////
	// Controllers
	////////////////////

	edge_job_control i_edge_job_control (
		.clock       (clock      ),
		.rstn        (rstn       ),
		.enabled     (enabled    ),
		.job         (queued_job ),
		.job_pop     (job_pop    ),
		.stall       (stall      ),
		.vertex_done (vertex_done),
		.edge_command(job_command),
		.current_job (current_job)
	);

	edge_data_control i_edge_data_control (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.enabled            (enabled            ),
		.edge_array_response(edge_array_response),
		.edge_command       (data_command       )
	);

	read_command_arbiter i_read_command_arbiter (
		.clock       (clock                   ),
		.rstn        (rstn                    ),
		.job_command (job_command             ),
		.data_command(data_command            ),
		.stall       (stall                   ),
		.bus_grant   (read_command_bus_grant  ),
		.bus_request (read_command_bus_request),
		.command_out (read_command_out        )
	);

	// Sum and completion
	rank_sum_kernel i_rank_sum_kernel (
		.clock              (clock              ),
		.rstn               (rstn               ),
		.current_job        (current_job        ),
		.graph_data_response(graph_data_response),
		.vertex_done        (vertex_done        ),
		.edge_write         (edge_data_write_out),
		.vertex_num_counter (vertex_num_counter ),
		.edge_num_counter   (edge_num_counter   )
	);

endmodule

/* verilog/rank_sum_kernel.sv */
// Rank sum kernel, accumulates neighbour ranks per vertex and emits the vertex write
`timescale 1ns/1ps

module rank_sum_kernel (
	input  logic                                   clock,
	input  logic                                   rstn,
	input  pagerank_pkg::vertex_job_t              current_job,
	input  pagerank_pkg::read_response_t           graph_data_response,
	output logic                                   vertex_done,
	output pagerank_pkg::edge_write_t              edge_write,
	output logic [pagerank_pkg::COUNTER_BITS-1:0] vertex_num_counter,
	output logic [pagerank_pkg::COUNTER_BITS-1:0] edge_num_counter
);

	logic [pagerank_pkg::RANK_BITS-1:0]       sum;
	logic [pagerank_pkg::RANK_BITS-1:0]       sum_next;
	logic [pagerank_pkg::EDGE_COUNT_BITS-1:0] tally;
	logic [pagerank_pkg::EDGE_COUNT_BITS-1:0] tally_next;
	logic                                     complete;
	logic                                     write_valid;
	logic [pagerank_pkg::VERTEX_ID_BITS-1:0]  write_vertex_id;
	logic [pagerank_pkg::RANK_BITS-1:0]       write_sum;

	////////////////////
	// Accumulate
	////////////////////

	always_comb begin
		sum_next   = sum;
		tally_next = tally;
		if (graph_data_response.valid) begin
			// Wraps at 32 bits
			sum_next   = sum + graph_data_response.word.graph_data;
			tally_next = tally + 1'b1;
		end
		// Done pulse masks the cycle before the job register clears
		complete = current_job.valid && !vertex_done && (tally_next == current_job.edge_count);
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sum                <= '0;
			tally              <= '0;
			vertex_done        <= 1'b0;
			write_valid        <= 1'b0;
			vertex_num_counter <= '0;
			edge_num_counter   <= '0;
		end else begin
			sum         <= complete ? '0 : sum_next;
			tally       <= complete ? '0 : tally_next;
			vertex_done <= complete;
			write_valid <= complete;
			if (complete) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
			if (graph_data_response.valid) begin
				edge_num_counter <= edge_num_counter + 1'b1;
			end
		end
	end

	////////////////////
	// Write strobe
	////////////////////

	always_ff @(posedge clock) begin
		if (complete) begin
			write_vertex_id <= current_job.vertex_id;
			write_sum       <= sum_next;
		end
	end

	always_comb begin
		edge_write.valid     = write_valid;
		edge_write.vertex_id = write_vertex_id;
		edge_write.rank_sum  = write_sum;
	end

endmodule

/* verilog/read_command_arbiter.sv */
// Read command arbiter merging both sources round-robin into a bus-drained command queue
`timescale 1ns/1ps

module read_command_arbiter (
	input  logic                        clock,
	input  logic                        rstn,
	input  pagerank_pkg::read_command_t job_command,
	input  pagerank_pkg::read_command_t data_command,
	output logic                        stall,
	input  logic                        bus_grant,
	output logic                        bus_request,
	output pagerank_pkg::read_command_t command_out
);

	pagerank_pkg::read_command_t push_command;
	pagerank_pkg::read_command_t skid;
	pagerank_pkg::read_command_t skid_next;
	logic                        prefer_data;
	logic                        conflict;
	logic                        grant_r;
	logic                        queue_almost_full;
	logic                        queue_empty;

	////////////////////
	// Source merge
	////////////////////

	always_comb begin
		push_command = '0;
		skid_next    = '0;
		conflict     = 1'b0;
		if (skid.valid) begin
			// Held loser goes first while the job source is stalled
			push_command = skid;
			skid_next    = data_command;
		end else if (job_command.valid && data_command.valid) begin
			conflict = 1'b1;
			if (prefer_data) begin
				push_command = data_command;
				skid_next    = job_command;
			end else begin
				push_command = job_command;
				skid_next    = data_command;
			end
		end else if (data_command.valid) begin
			push_command = data_command;
		end else begin
			push_command = job_command;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			skid        <= '0;
			prefer_data <= 1'b0;
		end else begin
			skid <= skid_next;
			if (conflict) begin
				prefer_data <= !prefer_data;
			end
		end
	end

	// An occupied skid also holds the job source so it can never overflow
	assign stall = queue_almost_full || skid.valid;

	////////////////////
	// Bus side
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant_r     <= 1'b0;
			bus_request <= 1'b0;
		end else begin
			grant_r     <= bus_grant;
			bus_request <= !queue_empty;
		end
	end

	// Queue output register is the command output register
	sync_fifo #(
		.WIDTH($bits(pagerank_pkg::read_command_t)),
		.DEPTH(pagerank_pkg::READ_CMD_QUEUE_DEPTH )
	) i_command_queue (
		.clock      (clock             ),
		.rstn       (rstn              ),
		.push       (push_command.valid),
		.data_in    (push_command      ),
		.pop        (grant_r           ),
		.data_out   (command_out       ),
		.full       (                  ),
		.almost_full(queue_almost_full ),
		.empty      (queue_empty       )
	);

endmodule

/* verilog/edge_data_control.sv */
// Edge data controller, turns each returned neighbour id into a graph-data read
`timescale 1ns/1ps

module edge_data_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  pagerank_pkg::read_response_t edge_array_response,
	output pagerank_pkg::read_command_t  edge_command
);

	logic                                    command_valid;
	logic [pagerank_pkg::VERTEX_ID_BITS-1:0] command_address;

	// No stall here, the command queue margin covers reads already in flight
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			command_valid <= 1'b0;
		end else begin
			command_valid <= enabled && edge_array_response.valid;
		end
	end

	// Neighbour id through the edge-array view of the word
	always_ff @(posedge clock) begin
		command_address <= edge_array_response.word.edge_array.neighbour_id;
	end

	always_comb begin
		edge_command.valid   = command_valid;
		edge_command.tag     = pagerank_pkg::GRAPH_DATA;
		edge_command.address = command_address;
	end

endmodule

/* verilog/edge_job_control.sv */
// Edge job controller, takes one vertex job at a time and issues its edge-array reads
`timescale 1ns/1ps

module edge_job_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  pagerank_pkg::vertex_job_t   job,
	output logic                        job_pop,
	input  logic                        stall,
	input  logic                        vertex_done,
	output pagerank_pkg::read_command_t edge_command,
	output pagerank_pkg::vertex_job_t   current_job
);

	pagerank_pkg::vertex_job_t                job_r;
	logic                                     busy;
	logic                                     pop_pending;
	logic [pagerank_pkg::EDGE_COUNT_BITS-1:0] edge_index;
	logic                                     issue;

	// Pop speculatively when idle, the queue output valid bit tells if a job came
	assign job_pop = enabled && !busy && !pop_pending;

	// One edge read per free cycle until the count is reached
	assign issue = busy && enabled && !stall && (edge_index != job_r.edge_count);

	always_comb begin
		edge_command.valid   = issue;
		edge_command.tag     = pagerank_pkg::EDGE_ARRAY;
		edge_command.address = job_r.edge_start + edge_index;
	end

	always_comb begin
		current_job       = job_r;
		current_job.valid = busy;
	end

	always_ff @(posedge clock) begin
		if (pop_pending && job.valid) begin
			job_r <= job;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			busy        <= 1'b0;
			pop_pending <= 1'b0;
			edge_index  <= '0;
		end else begin
			pop_pending <= job_pop;
			if (pop_pending && job.valid) begin
				busy       <= 1'b1;
				edge_index <= '0;
			end else begin
				// Vertex stays busy until the sum kernel reports it done
				if (vertex_done) begin
					busy <= 1'b0;
				end
				if (issue) begin
					edge_index <= edge_index + 1'b1;
				end
			end
		end
	end

endmodule

/* verilog/response_decoder.sv */
// Read response decoder that registers the response and routes it by array tag
`timescale 1ns/1ps

module response_decoder (
	input  logic                        clock,
	input  logic                        rstn,
	input  pagerank_pkg::read_response_t response,
	output pagerank_pkg::read_response_t edge_array_response,
	output pagerank_pkg::read_response_t graph_data_response
);

	pagerank_pkg::read_response_t response_r;
	pagerank_pkg::array_tag_t     payload_tag;
	pagerank_pkg::response_word_u payload_word;
	logic                         edge_valid;
	logic                         graph_valid;

	////////////////////
	// Capture stage
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			response_r <= '0;
		end else begin
			response_r <= response;
		end
	end

	////////////////////
	// Route stage
	////////////////////

	// Idle tag falls through to neither output
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_valid  <= 1'b0;
			graph_valid <= 1'b0;
		end else begin
			edge_valid  <= response_r.valid && (response_r.tag == pagerank_pkg::EDGE_ARRAY);
			graph_valid <= response_r.valid && (response_r.tag == pagerank_pkg::GRAPH_DATA);
		end
	end

	always_ff @(posedge clock) begin
		payload_tag  <= response_r.tag;
		payload_word <= response_r.word;
	end

	// Both outputs share the payload and differ only in valid
	always_comb begin
		edge_array_response.valid = edge_valid;
		edge_array_response.tag   = payload_tag;
		edge_array_response.word  = payload_word;
		graph_data_response.valid = graph_valid;
		graph_data_response.tag   = payload_tag;
		graph_data_response.word  = payload_word;
	end

endmodule

/* verilog/sync_fifo.sv */
// Synchronous FIFO with a registered one-cycle output and full, almost-full, empty flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	logic [WIDTH-1:0]           mem [0:DEPTH-1];
	logic [$clog2(DEPTH)-1:0]   wr_ptr;
	logic [$clog2(DEPTH)-1:0]   rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_push;
	logic                       do_pop;

	// Push on full and pop on empty are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	assign full        = (int'(count) == DEPTH);
	assign empty       = (count == '0);
	// Four or fewer free slots left
	assign almost_full = ((DEPTH - int'(count)) <= 4);

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			count    <= '0;
			data_out <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			// Popped word shows for one cycle, zero otherwise
			data_out <= do_pop ? mem[rd_ptr] : '0;
		end
	end

endmodule

/* verilog/pagerank_pkg.sv */
// PageRank compute unit shared widths, tags, bus structs and queue depths
package pagerank_pkg;

	////////////////////
	// Widths and depths
	////////////////////

	localparam int VERTEX_ID_BITS       = 16;
	localparam int EDGE_COUNT_BITS      = 16;
	localparam int RANK_BITS            = 32;
	localparam int COUNTER_BITS         = 32;
	localparam int VERTEX_QUEUE_DEPTH   = 16;
	localparam int READ_CMD_QUEUE_DEPTH = 16;

	////////////////////
	// Types
	////////////////////

	// Target array of a read, idle code is never issued
	typedef enum logic [1:0] {
		ARRAY_IDLE = 2'b00,
		EDGE_ARRAY = 2'b01,
		GRAPH_DATA = 2'b10
	} array_tag_t;

	typedef struct packed {
		logic                       valid;
		logic [VERTEX_ID_BITS-1:0]  vertex_id;
		logic [VERTEX_ID_BITS-1:0]  edge_start;
		logic [EDGE_COUNT_BITS-1:0] edge_count;
	} vertex_job_t;

	typedef struct packed {
		logic                      valid;
		array_tag_t                tag;
		logic [VERTEX_ID_BITS-1:0] address;
	} read_command_t;

	// One response word, seen as a neighbour id or as a rank value
	typedef union packed {
		struct packed {
			logic [RANK_BITS-VERTEX_ID_BITS-1:0] pad;
			logic [VERTEX_ID_BITS-1:0]           neighbour_id;
		} edge_array;
		logic [RANK_BITS-1:0] graph_data;
	} response_word_u;

	typedef struct packed {
		logic           valid;
		array_tag_t     tag;
		response_word_u word;
	} read_response_t;

	typedef struct packed {
		logic                      valid;
		logic [VERTEX_ID_BITS-1:0] vertex_id;
		logic [RANK_BITS-1:0]      rank_sum;
	} edge_write_t;

endpackage
